// File: rtl/elevator_controller.sv
/* Elevator FSM. Takes one order at a time from the queue, swaps the plate when
   needed, moves one floor per clock and parks or fetches the car. */
`timescale 1ns/100ps

module elevator_controller (
	input logic clock,
	input logic reset,
	input logic order_valid,
	input parking_pkg::order_kind_t order_kind,
	input parking_pkg::plate_t order_plate_q,
	input parking_pkg::floor_t free_floor,
	input logic free_place,
	input logic free_found,
	input parking_pkg::floor_t hit_floor,
	input logic hit_place,
	input logic hit_found,
	input parking_pkg::fee_t spot_fee,
	output logic order_take,
	output parking_pkg::plate_t query_plate,
	output logic store_strobe,
	output parking_pkg::plate_t store_plate,
	output logic clear_strobe,
	output parking_pkg::floor_t spot_floor,
	output logic spot_place,
	output parking_pkg::floor_t current_floor,
	output logic plate_type,
	output logic park_done,
	output logic car_out,
	output parking_pkg::plate_t car_out_plate,
	output parking_pkg::fee_t fee,
	output logic order_rejected
);
	parking_pkg::elevator_state_t state;
	parking_pkg::elevator_state_t state_next;
	parking_pkg::order_kind_t kind_r; // Order in progress
	parking_pkg::plate_t plate_r;
	logic swap_needed;
	logic load_reject;
	logic arriving_home;

	assign swap_needed = (order_plate_q[0] != plate_type);
	assign load_reject = (plate_r == '0) || !free_found;

	// Lookup uses the queue head while idle, then the latched plate
	assign query_plate = (state == parking_pkg::st_idle) ? order_plate_q : plate_r;
	assign order_take = (state == parking_pkg::st_idle) && order_valid;

	assign store_strobe = (state == parking_pkg::st_store);
	assign clear_strobe = (state == parking_pkg::st_pickup);
	assign store_plate = plate_r;
	assign park_done = (state == parking_pkg::st_store);
	assign car_out_plate = plate_r;

	assign order_rejected = (order_take && order_kind == parking_pkg::order_retrieve && !hit_found)
		|| (state == parking_pkg::st_load && load_reject);

	// Last step down to the entrance with a car aboard
	assign arriving_home = (current_floor == 3'd1)
		&& (state == parking_pkg::st_pickup
		|| (state == parking_pkg::st_travel_home && kind_r == parking_pkg::order_retrieve));

	always_comb begin
		state_next = state;
		case (state)
			parking_pkg::st_idle: begin
				if (order_valid) begin
					if (order_kind == parking_pkg::order_park)
						state_next = swap_needed ? parking_pkg::st_plate_swap : parking_pkg::st_load;
					else if (hit_found)
						state_next = swap_needed ? parking_pkg::st_plate_swap
							: parking_pkg::st_travel_out;
				end
			end
			parking_pkg::st_plate_swap: begin
				state_next = (kind_r == parking_pkg::order_park) ? parking_pkg::st_load
					: parking_pkg::st_travel_out;
			end
			parking_pkg::st_load:
				state_next = load_reject ? parking_pkg::st_idle : parking_pkg::st_travel_out;
			parking_pkg::st_travel_out: begin
				if (parking_pkg::floor_t'(current_floor + 3'd1) == spot_floor)
					state_next = (kind_r == parking_pkg::order_park) ? parking_pkg::st_store
						: parking_pkg::st_pickup;
			end
			parking_pkg::st_store, parking_pkg::st_pickup:
				state_next = (current_floor == 3'd1) ? parking_pkg::st_idle
					: parking_pkg::st_travel_home;
			parking_pkg::st_travel_home: begin
				if (current_floor == 3'd1)
					state_next = parking_pkg::st_idle;
			end
			default: state_next = parking_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= parking_pkg::st_idle;
			current_floor <= '0;
			plate_type <= 1'b0; // Sedan plate
			car_out <= 1'b0;
			fee <= '0;
		end else begin
			state <= state_next;
			car_out <= arriving_home;
			case (state)
				parking_pkg::st_plate_swap: plate_type <= !plate_type;
				parking_pkg::st_travel_out: current_floor <= current_floor + 3'd1;
				parking_pkg::st_store, parking_pkg::st_travel_home:
					current_floor <= current_floor - 3'd1; // Heading home
				parking_pkg::st_pickup: begin
					current_floor <= current_floor - 3'd1;
					fee <= spot_fee; // Meter already holds the full charge
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (order_take) begin
			plate_r <= order_plate_q;
			kind_r <= order_kind;
			spot_floor <= hit_floor; // Retrieve target, replaced at load for parking
			spot_place <= hit_place;
		end else if (state == parking_pkg::st_load) begin
			spot_floor <= free_floor;
			spot_place <= free_place;
		end
	end

endmodule

// File: rtl/fee_meter.sv
/* Fee counter of one parking spot. Charges per cycle by car class while
   the spot is occupied, saturating at the fee limit. */
`timescale 1ns/100ps

module fee_meter (
	input logic clock,
	input logic reset,
	input logic occupied,
	input logic start,
	input logic [3:0] car_class,
	output parking_pkg::fee_t fee
);
	logic [1:0] rate;
	logic [8:0] sum;

	always_comb begin
		if (car_class == parking_pkg::CLASS_HANDICAPPED)
			rate = 2'd0;
		else if (car_class == parking_pkg::CLASS_HYBRID)
			rate = 2'd1;
		else
			rate = 2'd2;
	end

	assign sum = {1'b0, fee} + {7'b0, rate}; // One bit of headroom for saturation

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			fee <= '0;
		end else if (start) begin
			fee <= {6'b0, rate}; // New car, the store cycle is the first charged
		end else if (occupied) begin
			if (sum > {1'b0, parking_pkg::FEE_MAX})
				fee <= parking_pkg::FEE_MAX;
			else
				fee <= sum[7:0];
		end
	end

endmodule

// File: rtl/order_queue.sv
/* Circular buffer of park and retrieve orders waiting for the elevator.
   Both strobes at once count as a retrieval; a strobe into a full buffer is dropped. */
`timescale 1ns/100ps

module order_queue (
	input logic clock,
	input logic reset,
	input logic park_req,
	input logic retrieve_req,
	input parking_pkg::plate_t order_plate,
	input logic order_take,
	output logic order_valid,
	output parking_pkg::order_kind_t order_kind,
	output parking_pkg::plate_t order_plate_q,
	output logic order_dropped
);
	parking_pkg::plate_t plate_mem [parking_pkg::QUEUE_DEPTH];
	parking_pkg::order_kind_t kind_mem [parking_pkg::QUEUE_DEPTH];
	logic [$clog2(parking_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(parking_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(parking_pkg::QUEUE_DEPTH):0] count;
	logic strobe;
	logic full;
	logic push;
	logic pop;

	assign strobe = park_req || retrieve_req;
	assign full = (count == parking_pkg::QUEUE_DEPTH);
	assign push = strobe && !full;
	assign pop = order_take && order_valid;

	// Head of the queue seen directly by the controller
	assign order_valid = (count != '0);
	assign order_kind = kind_mem[rd_ptr];
	assign order_plate_q = plate_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[wr_ptr] <= order_plate;
			kind_mem[wr_ptr] <= retrieve_req ? parking_pkg::order_retrieve
				: parking_pkg::order_park;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			order_dropped <= 1'b0;
		end else begin
			order_dropped <= strobe && full; // Order is lost
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, pointers wrap
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/parking_lot_top.sv
/* Top level of the parking tower. Connects the order queue, the elevator
   controller and the spot table; park_floor and park_place go with park_done. */
`timescale 1ns/100ps

module parking_lot_top (
	input logic clock,
	input logic reset,
	input logic park_req,
	input logic retrieve_req,
	input parking_pkg::plate_t order_plate,
	output parking_pkg::floor_t current_floor,
	output logic plate_type,
	output logic park_done,
	output parking_pkg::floor_t park_floor,
	output logic park_place,
	output logic car_out,
	output parking_pkg::plate_t car_out_plate,
	output parking_pkg::fee_t fee,
	output logic order_rejected,
	output logic order_dropped,
	output logic full_sedan,
	output logic full_suv
);
	logic order_valid;
	logic order_take;
	parking_pkg::order_kind_t order_kind;
	parking_pkg::plate_t order_plate_q;
	parking_pkg::plate_t query_plate;
	parking_pkg::plate_t store_plate;
	logic store_strobe;
	logic clear_strobe;
	parking_pkg::floor_t free_floor;
	logic free_place;
	logic free_found;
	parking_pkg::floor_t hit_floor;
	logic hit_place;
	logic hit_found;
	parking_pkg::fee_t spot_fee;

	order_queue queue_i (
		.clock(clock),
		.reset(reset),
		.park_req(park_req),
		.retrieve_req(retrieve_req),
		.order_plate(order_plate),
		.order_take(order_take),
		.order_valid(order_valid),
		.order_kind(order_kind),
		.order_plate_q(order_plate_q),
		.order_dropped(order_dropped)
	);

	// Spot outputs double as the reported park position
	elevator_controller controller_i (
		.clock(clock),
		.reset(reset),
		.order_valid(order_valid),
		.order_kind(order_kind),
		.order_plate_q(order_plate_q),
		.free_floor(free_floor),
		.free_place(free_place),
		.free_found(free_found),
		.hit_floor(hit_floor),
		.hit_place(hit_place),
		.hit_found(hit_found),
		.spot_fee(spot_fee),
		.order_take(order_take),
		.query_plate(query_plate),
		.store_strobe(store_strobe),
		.store_plate(store_plate),
		.clear_strobe(clear_strobe),
		.spot_floor(park_floor),
		.spot_place(park_place),
		.current_floor(current_floor),
		.plate_type(plate_type),
		.park_done(park_done),
		.car_out(car_out),
		.car_out_plate(car_out_plate),
		.fee(fee),
		.order_rejected(order_rejected)
	);

	slot_table slots_i (
		.clock(clock),
		.reset(reset),
		.store_strobe(store_strobe),
		.store_plate(store_plate),
		.clear_strobe(clear_strobe),
		.spot_floor(park_floor),
		.spot_place(park_place),
		.query_plate(query_plate),
		.free_floor(free_floor),
		.free_place(free_place),
		.free_found(free_found),
		.hit_floor(hit_floor),
		.hit_place(hit_place),
		.hit_found(hit_found),
		.spot_fee(spot_fee),
		.full_sedan(full_sedan),
		.full_suv(full_suv)
	);

endmodule

// File: rtl/parking_pkg.sv
/* Types and constants shared by the parking tower RTL and its testbench.
   Modules refer to them by scoped names. */
package parking_pkg;

	// Bit 0 set for an SUV, bits 15:12 hold the car class, zero means no car
	typedef logic [15:0] plate_t;

	typedef logic [2:0] floor_t; // Floor 0 is the entrance
	typedef logic [7:0] fee_t;

	typedef enum logic {
		order_park,
		order_retrieve
	} order_kind_t;

	typedef enum logic [2:0] {
		st_idle,        // Waiting at floor 0 for an order
		st_plate_swap,  // Exchange sedan and SUV plate
		st_load,        // Car rolls onto the plate, spot chosen
		st_travel_out,
		st_store,       // Car leaves the plate into its spot
		st_pickup,      // Car taken from its spot
		st_travel_home
	} elevator_state_t;

	// Parking floors above the entrance, two spots each
	localparam int NUM_FLOORS = 7;

	// Pending orders
	localparam int QUEUE_DEPTH = 8;

	// Car class codes in plate bits 15:12
	localparam logic [3:0] CLASS_HANDICAPPED = 4'b1001;
	localparam logic [3:0] CLASS_HYBRID = 4'b1000;

	// Fee saturates here
	localparam fee_t FEE_MAX = 8'd255;

endpackage

// File: rtl/slot_table.sv
/* Plates of all fourteen spots with their fee meters. Finds the lowest allowed
   free spot and the spot holding a given plate for the elevator controller. */
`timescale 1ns/100ps

module slot_table (
	input logic clock,
	input logic reset,
	input logic store_strobe,
	input parking_pkg::plate_t store_plate,
	input logic clear_strobe,
	input parking_pkg::floor_t spot_floor,
	input logic spot_place,
	input parking_pkg::plate_t query_plate,
	output parking_pkg::floor_t free_floor,
	output logic free_place,
	output logic free_found,
	output parking_pkg::floor_t hit_floor,
	output logic hit_place,
	output logic hit_found,
	output parking_pkg::fee_t spot_fee,
	output logic full_sedan,
	output logic full_suv
);
	// Place 0 is the left spot; a zero plate marks a free spot
	parking_pkg::plate_t spots [1:parking_pkg::NUM_FLOORS][2];
	parking_pkg::fee_t fees [1:parking_pkg::NUM_FLOORS][2];
	logic suv_query;

	assign suv_query = query_plate[0];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
				spots[f][0] <= '0;
				spots[f][1] <= '0;
			end
		end else if (store_strobe || clear_strobe) begin
			for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
				if (spot_floor == parking_pkg::floor_t'(f))
					spots[f][spot_place] <= store_strobe ? store_plate : '0;
			end
		end
	end

	// Even floors are sedan floors, odd floors SUV floors
	always_comb begin
		full_sedan = 1'b1;
		full_suv = 1'b1;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			if (f % 2 == 0)
				full_sedan = full_sedan && (spots[f][0] != '0) && (spots[f][1] != '0);
			else
				full_suv = full_suv && (spots[f][0] != '0) && (spots[f][1] != '0);
		end
	end

	always_comb begin
		logic allowed;
		free_found = 1'b0;
		free_floor = '0;
		free_place = 1'b0;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			// Sedans overflow to odd floors once the even ones are full
			allowed = (f % 2 == 1) ? (suv_query || full_sedan) : !suv_query;
			if (allowed && !free_found && (spots[f][0] == '0 || spots[f][1] == '0)) begin
				free_found = 1'b1;
				free_floor = parking_pkg::floor_t'(f);
				free_place = (spots[f][0] != '0); // Left spot first
			end
		end
	end

	always_comb begin
		hit_found = 1'b0;
		hit_floor = '0;
		hit_place = 1'b0;
		spot_fee = '0;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (!hit_found && spots[f][p] != '0 && spots[f][p] == query_plate) begin
					hit_found = 1'b1;
					hit_floor = parking_pkg::floor_t'(f);
					hit_place = (p == 1);
				end
				if (spot_floor == parking_pkg::floor_t'(f) && spot_place == (p == 1))
					spot_fee = fees[f][p];
			end
		end
	end

	for (genvar f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin : g_floor
		for (genvar p = 0; p < 2; p++) begin : g_place
			logic meter_start;

			assign meter_start = store_strobe && spot_floor == parking_pkg::floor_t'(f)
				&& spot_place == (p == 1);

			fee_meter meter_i (
				.clock(clock),
				.reset(reset),
				.occupied(spots[f][p] != '0),
				.start(meter_start),
				.car_class(meter_start ? store_plate[15:12] : spots[f][p][15:12]), // Incoming car
				.fee(fees[f][p])
			);
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the parking tower testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module parking_lot_tb \
	-o parking_lot_sim

./obj_dir/parking_lot_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation log is clean"
exit 0

// File: testbench/parking_lot_tb.sv
/* Testbench for the parking tower. Applies a table of park and retrieve orders
   and checks every completion against a model of the spots, fees and plate. */
`timescale 1ns/100ps

module parking_lot_tb;

	typedef struct packed {
		parking_pkg::order_kind_t kind;
		parking_pkg::plate_t plate;
		logic random_gap;  // Idle cycles from the LFSR before the strobe
		logic expect_drop;
		logic drain;       // Let every issued order finish first
	} order_row_t;

	localparam int NUM_ROWS = 39;
	localparam int ROW_CYCLES = 2 * parking_pkg::NUM_FLOORS + 4;
	localparam int TAIL_CYCLES = 20;

	logic clock;
	logic reset;
	logic park_req;
	logic retrieve_req;
	parking_pkg::plate_t order_plate;
	parking_pkg::floor_t current_floor;
	logic plate_type;
	logic park_done;
	parking_pkg::floor_t park_floor;
	logic park_place;
	logic car_out;
	parking_pkg::plate_t car_out_plate;
	parking_pkg::fee_t fee;
	logic order_rejected;
	logic order_dropped;
	logic full_sedan;
	logic full_suv;

	// Class in bits 15:12, bit 0 set for an SUV
	order_row_t order_table [NUM_ROWS] = '{
		'{parking_pkg::order_park, 16'h1002, 1'b1, 1'b0, 1'b1}, // Sedans fill even floors
		'{parking_pkg::order_park, 16'h8004, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h9006, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h1008, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h100a, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h800c, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h100e, 1'b1, 1'b0, 1'b1}, // Overflow to floor 1
		'{parking_pkg::order_park, 16'h1011, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h8013, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h9015, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h1017, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h1019, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h101b, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h101d, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h101f, 1'b1, 1'b0, 1'b1}, // Tower full
		'{parking_pkg::order_park, 16'h0000, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h2222, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h1002, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h1020, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h9006, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h8013, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h101d, 1'b1, 1'b0, 1'b0}, // Long trip to floor 7
		'{parking_pkg::order_retrieve, 16'h1008, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_park, 16'h1021, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_retrieve, 16'h1011, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_park, 16'h1023, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_retrieve, 16'h100a, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_retrieve, 16'h4444, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_park, 16'h0000, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_retrieve, 16'h800c, 1'b0, 1'b0, 1'b0},
		'{parking_pkg::order_park, 16'h1025, 1'b0, 1'b1, 1'b1}, // Ninth strobe, queue full
		'{parking_pkg::order_retrieve, 16'h100e, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h9027, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h9027, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h1019, 1'b1, 1'b0, 1'b1}, // Fee saturates
		'{parking_pkg::order_park, 16'h1029, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h1029, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_park, 16'h802b, 1'b1, 1'b0, 1'b1},
		'{parking_pkg::order_retrieve, 16'h802b, 1'b1, 1'b0, 1'b1}
	};

	parking_pkg::plate_t model_spot [1:parking_pkg::NUM_FLOORS][2];
	int park_stamp [1:parking_pkg::NUM_FLOORS][2]; // Cycle of park_done
	logic model_type;
	order_row_t pending [$];
	int gaps [NUM_ROWS];
	int cycle_count;
	int watchdog_cycles = 0;
	int cycle_limit;
	int error_count;
	logic [31:0] lfsr_state;

	parking_lot_top dut_i (.*);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		watchdog_cycles++;
		if (watchdog_cycles > cycle_limit) begin
			$display("Timeout after %0d cycles with %0d orders outstanding, %0d errors",
				watchdog_cycles, pending.size(), error_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int draw_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	function automatic int class_rate(input parking_pkg::plate_t plate);
		int rate;
		rate = 2;
		if (plate[15:12] == parking_pkg::CLASS_HANDICAPPED)
			rate = 0;
		else if (plate[15:12] == parking_pkg::CLASS_HYBRID)
			rate = 1;
		return rate;
	endfunction

	// Sedans try even floors, then odd ones; SUVs only odd floors
	function automatic logic find_free(input parking_pkg::plate_t plate,
			output int fl, output int pl);
		logic found;
		int start;
		found = 1'b0;
		fl = 0;
		pl = 0;
		for (int pass = 0; pass < 2; pass++) begin
			start = (pass == 0 && !plate[0]) ? 2 : 1;
			if (!(pass == 1 && plate[0])) begin
				for (int f = start; f <= parking_pkg::NUM_FLOORS; f += 2) begin
					for (int p = 0; p < 2; p++) begin
						if (!found && model_spot[f][p] == '0) begin
							found = 1'b1;
							fl = f;
							pl = p;
						end
					end
				end
			end
		end
		return found;
	endfunction

	function automatic logic find_plate(input parking_pkg::plate_t plate,
			output int fl, output int pl);
		logic found;
		found = 1'b0;
		fl = 0;
		pl = 0;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (!found && model_spot[f][p] != '0 && model_spot[f][p] == plate) begin
					found = 1'b1;
					fl = f;
					pl = p;
				end
			end
		end
		return found;
	endfunction

	task automatic check(input logic ok, input string what);
		assert (ok) else begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s", $time, what);
		end
	endtask

	task automatic check_full();
		logic even_full;
		logic odd_full;
		even_full = 1'b1;
		odd_full = 1'b1;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (model_spot[f][p] == '0 && f % 2 == 0)
					even_full = 1'b0;
				else if (model_spot[f][p] == '0)
					odd_full = 1'b0;
			end
		end
		check(full_sedan == even_full && full_suv == odd_full,
			$sformatf("full flags %b%b, expected %b%b", full_sedan, full_suv, even_full, odd_full));
		check(plate_type == model_type,
			$sformatf("plate_type %b, expected %b", plate_type, model_type));
	endtask

	task automatic take_head(input string pulse, output logic ok, output order_row_t head);
		ok = (pending.size() != 0);
		head = '0;
		assert (ok) else begin
			error_count++;
			$display("Unexpected %s pulse at %0t ns while no order was outstanding", pulse, $time);
		end
		if (ok)
			head = pending.pop_front();
	endtask

	task automatic on_park_done();
		order_row_t head;
		logic ok;
		logic expected;
		int fl;
		int pl;
		take_head("park_done", ok, head);
		if (ok) begin
			expected = head.kind == parking_pkg::order_park && head.plate != '0
				&& find_free(head.plate, fl, pl);
			check(expected, $sformatf("park_done for order %h not expected", head.plate));
			if (expected) begin
				check(int'(park_floor) == fl && int'(park_place) == pl
					&& int'(current_floor) == fl,
					$sformatf("plate %h parked at %0d/%0d floor %0d, expected %0d/%0d",
					head.plate, park_floor, park_place, current_floor, fl, pl));
				model_type = head.plate[0];
				check_full(); // Spot is written at the end of this cycle
				model_spot[fl][pl] = head.plate;
				park_stamp[fl][pl] = cycle_count;
			end
		end
	endtask

	task automatic on_car_out();
		order_row_t head;
		logic ok;
		logic expected;
		int fl;
		int pl;
		int want_fee;
		take_head("car_out", ok, head);
		if (ok) begin
			expected = head.kind == parking_pkg::order_retrieve && find_plate(head.plate, fl, pl);
			check(expected, $sformatf("car_out for order %h not expected", head.plate));
			if (expected) begin
				want_fee = class_rate(head.plate) * (cycle_count - park_stamp[fl][pl] - fl);
				if (want_fee > 255)
					want_fee = 255;
				check(car_out_plate == head.plate && int'(fee) == want_fee && current_floor == '0,
					$sformatf("car_out plate %h fee %0d floor %0d, expected %h fee %0d",
					car_out_plate, fee, current_floor, head.plate, want_fee));
				model_spot[fl][pl] = '0;
				model_type = head.plate[0];
				check_full();
			end
		end
	endtask

	task automatic on_reject();
		order_row_t head;
		logic ok;
		logic expected;
		int fl;
		int pl;
		take_head("order_rejected", ok, head);
		if (ok) begin
			if (head.kind == parking_pkg::order_park) begin
				expected = head.plate == '0 || !find_free(head.plate, fl, pl);
				model_type = head.plate[0]; // Plate swapped before the load cycle
			end else begin
				expected = !find_plate(head.plate, fl, pl);
			end
			check(expected, $sformatf("order %h rejected but should complete", head.plate));
			check_full();
		end
	endtask

	// Outputs are sampled mid-cycle, before new inputs are driven
	task automatic step_cycle();
		@(negedge clock);
		cycle_count++;
		if (car_out)
			on_car_out();
		if (park_done)
			on_park_done();
		if (order_rejected)
			on_reject();
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		park_req = 1'b0;
		retrieve_req = 1'b0;
		order_plate = '0;
		cycle_count = 0;
		error_count = 0;
		model_type = 1'b0;
		lfsr_state = 32'h548666ce;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			model_spot[f] = '{'0, '0};
			park_stamp[f] = '{0, 0};
		end
		cycle_limit = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			gaps[i] = order_table[i].random_gap ? draw_bits(2) : 0;
			cycle_limit += ROW_CYCLES + gaps[i];
		end
		cycle_limit = 2 * cycle_limit + 4 + TAIL_CYCLES;

		repeat (4) @(negedge clock);
		reset = 1'b0;
		step_cycle();
		check(!park_done && !car_out && !order_rejected && !order_dropped
			&& current_floor == '0 && plate_type == 1'b0 && fee == '0,
			"outputs not idle after reset");

		for (int i = 0; i < NUM_ROWS; i++) begin
			repeat (gaps[i]) step_cycle();
			park_req = (order_table[i].kind == parking_pkg::order_park);
			retrieve_req = (order_table[i].kind == parking_pkg::order_retrieve);
			order_plate = order_table[i].plate;
			if (!order_table[i].expect_drop)
				pending.push_back(order_table[i]);
			step_cycle();
			park_req = 1'b0;
			retrieve_req = 1'b0;
			check(order_dropped == order_table[i].expect_drop,
				$sformatf("row %0d order_dropped %b", i, order_dropped));
			if (order_table[i].drain) begin
				while (pending.size() != 0)
					step_cycle();
			end
		end
		repeat (TAIL_CYCLES) step_cycle(); // Any stray pulse is caught here

		$display("Errors: %0d, orders outstanding: %0d", error_count, pending.size());
		if (error_count == 0 && pending.size() == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
rtl/parking_pkg.sv
rtl/order_queue.sv
rtl/fee_meter.sv
rtl/slot_table.sv
rtl/elevator_controller.sv
rtl/parking_lot_top.sv
testbench/parking_lot_tb.sv
